// ==== sources.f ====
dpram_pkg.sv
shared_ram_core.sv
write_guard.sv
guard_regs.sv
shared_ram_top.sv
tb_clock_gen.sv
shared_ram_props.sv
shared_ram_tb.sv

// ==== Bender.yml ====
package:
  name: shared_ram

sources:
  - dpram_pkg.sv
  - shared_ram_core.sv
  - write_guard.sv
  - guard_regs.sv
  - shared_ram_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - shared_ram_props.sv
      - shared_ram_tb.sv

// ==== shared_ram_tb.sv ====
// Testbench top driving both ports and the lock registers with seeded random traffic.
`timescale 1ns/1ns

module shared_ram_tb import dpram_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  cs_a;
  logic                  we_a;
  logic [mask_w-1:0]     wem_a;
  logic [addr_w-1:0]     addr_a;
  logic [data_w-1:0]     din_a;
  logic [data_w-1:0]     dout_a;
  logic                  cs_b;
  logic                  we_b;
  logic [mask_w-1:0]     wem_b;
  logic [addr_w-1:0]     addr_b;
  logic [data_w-1:0]     din_b;
  logic [data_w-1:0]     dout_b;
  logic                  cfg_we;
  logic [cfg_addr_w-1:0] cfg_addr;
  logic [cfg_data_w-1:0] cfg_wdata;
  logic [cfg_data_w-1:0] cfg_rdata;
  logic [31:0]           rng_state = 32'hf557;
  int                    timeout_count = 0;
  int                    assert_errors;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  shared_ram_top shared_ram_top_inst (.*);

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 50) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was not released within 50 cycles");
      timeout_count++;
    end
  endtask

  // Write share is out of 128. Same-word cycles send both ports to one address.
  task automatic random_cycle(input int write_share, input bit same_word);
    logic [31:0] ctrl_a;
    logic [31:0] ctrl_b;
    @(posedge clk);
    ctrl_a = next_random();
    ctrl_b = next_random();
    cs_a   <= ctrl_a[31] | ctrl_a[30] | same_word;
    we_a   <= (int'(ctrl_a[29:23]) < write_share) | same_word;
    wem_a  <= ctrl_a[22:19];
    addr_a <= addr_w'(ctrl_a[18:13]); // Only 64 words, so collisions and window hits occur.
    din_a  <= next_random();
    cs_b   <= ctrl_b[31] | ctrl_b[30] | same_word;
    we_b   <= (int'(ctrl_b[29:23]) < write_share) | same_word;
    wem_b  <= ctrl_b[22:19];
    addr_b <= same_word ? addr_w'(ctrl_a[18:13]) : addr_w'(ctrl_b[18:13]);
    din_b  <= next_random();
  endtask

  task automatic idle_ports();
    cs_a <= 1'b0;
    we_a <= 1'b0;
    cs_b <= 1'b0;
    we_b <= 1'b0;
  endtask

  task automatic write_cfg(input logic [cfg_addr_w-1:0] addr,
                           input logic [cfg_data_w-1:0] data);
    @(posedge clk);
    idle_ports();
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic read_all_regs();
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      cfg_we   <= 1'b0;
      cfg_addr <= cfg_addr_w'(k);
    end
    @(posedge clk);
  endtask

  // Port B reads the word that port A writes in the same cycle.
  task automatic write_then_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge clk);
    cs_a   <= 1'b1;
    we_a   <= 1'b1;
    wem_a  <= '1;
    addr_a <= addr;
    din_a  <= data;
    cs_b   <= 1'b1;
    we_b   <= 1'b0;
    addr_b <= addr;
    @(posedge clk);
    idle_ports();
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_blocked_count();
    int cycles;
    cycles = 0;
    while (cfg_rdata == '0 && cycles < 200) begin
      random_cycle(80, 1'b0);
      @(negedge clk);
      cycles++;
    end
    if (cfg_rdata == '0) begin
      $display("timeout: no blocked write was counted within 200 cycles");
      timeout_count++;
    end
  endtask

  initial begin
    cs_a      = 1'b0;
    we_a      = 1'b0;
    wem_a     = '0;
    addr_a    = '0;
    din_a     = '0;
    cs_b      = 1'b0;
    we_b      = 1'b0;
    wem_b     = '0;
    addr_b    = '0;
    din_b     = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;

    wait_reset_release();
    read_all_regs();
    write_then_read(10'd5, 32'hcafe_f00d);
    write_then_read(10'd63, 32'h1234_5678);
    repeat (300) random_cycle(64, 1'b0);
    repeat (100) random_cycle(128, 1'b1);

    // Upper bits of base and limit are dropped, giving a window of words 10 to 30.
    write_cfg(reg_lock_base, 16'hfc0a);
    write_cfg(reg_lock_limit, 16'h841e);
    write_cfg(reg_lock_ctrl, 16'habcd);
    read_all_regs();
    cfg_addr <= reg_blocked_cnt;
    wait_blocked_count();
    repeat (200) random_cycle(80, 1'b0);
    random_cycle(80, 1'b1);
    cfg_we    <= 1'b1; // Clear while blocked writes keep arriving.
    cfg_wdata <= '0;
    random_cycle(80, 1'b1);
    cfg_we    <= 1'b0;
    repeat (100) random_cycle(80, 1'b1);

    write_cfg(reg_lock_ctrl, 16'h0000);
    repeat (100) random_cycle(64, 1'b0);
    read_all_regs();
    idle_ports();
    repeat (2) @(posedge clk);
    @(negedge clk); // The checks of the last edge have completed by now.

    assert_errors = shared_ram_top_inst.u_props.error_count;
    $display("assertion errors: %0d, timeouts: %0d", assert_errors, timeout_count);
    if (assert_errors == 0 && timeout_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== shared_ram_props.sv ====
// Bound checker with shadow memory, shadow lock registers and the scratchpad assertions.
`timescale 1ns/1ns

module shared_ram_props import dpram_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cs_a,
  input logic                  we_a,
  input logic [mask_w-1:0]     wem_a,
  input logic [addr_w-1:0]     addr_a,
  input logic [data_w-1:0]     din_a,
  input logic [data_w-1:0]     dout_a,
  input logic                  cs_b,
  input logic                  we_b,
  input logic [mask_w-1:0]     wem_b,
  input logic [addr_w-1:0]     addr_b,
  input logic [data_w-1:0]     din_b,
  input logic [data_w-1:0]     dout_b,
  input logic                  cfg_we,
  input logic [cfg_addr_w-1:0] cfg_addr,
  input logic [cfg_data_w-1:0] cfg_wdata,
  input logic [cfg_data_w-1:0] cfg_rdata
);

  int                    error_count = 0;
  logic [data_w-1:0]     shadow_mem [mem_depth];
  logic [addr_w-1:0]     raddr_a;
  logic [addr_w-1:0]     raddr_b;
  logic [addr_w-1:0]     win_base;
  logic [addr_w-1:0]     win_limit;
  logic                  win_en;
  logic [cfg_data_w-1:0] blk_count;
  logic                  hit_a;
  logic                  hit_b;
  logic [cfg_data_w:0]   count_sum;
  logic [data_w-1:0]     exp_dout_a;
  logic [data_w-1:0]     exp_dout_b;
  logic [cfg_data_w-1:0] exp_rdata;

  initial begin
    for (int w = 0; w < mem_depth; w++) begin
      shadow_mem[w] = '0;
    end
  end

  // A write request inside the enabled window is dropped as a whole.
  assign hit_a = cs_a && we_a && win_en && (addr_a >= win_base) && (addr_a <= win_limit);
  assign hit_b = cs_b && we_b && win_en && (addr_b >= win_base) && (addr_b <= win_limit);
  assign count_sum = {1'b0, blk_count} + {{cfg_data_w{1'b0}}, hit_a}
                   + {{cfg_data_w{1'b0}}, hit_b};

  // Port B lands first and port A lands after it, so A owns any shared byte.
  always_ff @(posedge clk) begin
    for (int i = 0; i < mask_w; i++) begin
      if (cs_b && we_b && wem_b[i] && !hit_b) begin
        shadow_mem[addr_b][8*i +: 8] <= din_b[8*i +: 8];
      end
      if (cs_a && we_a && wem_a[i] && !hit_a) begin
        shadow_mem[addr_a][8*i +: 8] <= din_a[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      raddr_a   <= '0;
      raddr_b   <= '0;
      win_base  <= '0;
      win_limit <= '0;
      win_en    <= 1'b0;
      blk_count <= '0;
    end else begin
      if (cs_a) raddr_a <= addr_a;
      if (cs_b) raddr_b <= addr_b;
      if (cfg_we && cfg_addr == reg_lock_base) win_base <= cfg_wdata[addr_w-1:0];
      if (cfg_we && cfg_addr == reg_lock_limit) win_limit <= cfg_wdata[addr_w-1:0];
      if (cfg_we && cfg_addr == reg_lock_ctrl) win_en <= cfg_wdata[0];
      if (cfg_we && cfg_addr == reg_blocked_cnt) begin
        blk_count <= '0;
      end else if (count_sum > {1'b0, cnt_max}) begin
        blk_count <= cnt_max;
      end else begin
        blk_count <= count_sum[cfg_data_w-1:0];
      end
    end
  end

  assign exp_dout_a = shadow_mem[raddr_a];
  assign exp_dout_b = shadow_mem[raddr_b];

  always_comb begin
    case (cfg_addr)
      reg_lock_base:  exp_rdata = cfg_data_w'(win_base);
      reg_lock_limit: exp_rdata = cfg_data_w'(win_limit);
      reg_lock_ctrl:  exp_rdata = cfg_data_w'(win_en);
      default:        exp_rdata = blk_count;
    endcase
  end

  a_dout_a: assert property (@(posedge clk) disable iff (!rst_n) dout_a == exp_dout_a)
    else begin
      $error("error %0t: dout_a is %h, expected %h", $time, $sampled(dout_a),
             $sampled(exp_dout_a));
      error_count++;
    end

  a_dout_b: assert property (@(posedge clk) disable iff (!rst_n) dout_b == exp_dout_b)
    else begin
      $error("error %0t: dout_b is %h, expected %h", $time, $sampled(dout_b),
             $sampled(exp_dout_b));
      error_count++;
    end

  a_cfg_rdata: assert property (@(posedge clk) disable iff (!rst_n) cfg_rdata == exp_rdata)
    else begin
      $error("error %0t: register %0d reads %h, expected %h", $time, $sampled(cfg_addr),
             $sampled(cfg_rdata), $sampled(exp_rdata));
      error_count++;
    end

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
                            !$isunknown({dout_a, dout_b, cfg_rdata}))
    else begin
      $error("error %0t: unknown bits on a read output", $time);
      error_count++;
    end

endmodule

bind shared_ram_top shared_ram_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .cs_a      (cs_a),
  .we_a      (we_a),
  .wem_a     (wem_a),
  .addr_a    (addr_a),
  .din_a     (din_a),
  .dout_a    (dout_a),
  .cs_b      (cs_b),
  .we_b      (we_b),
  .wem_b     (wem_b),
  .addr_b    (addr_b),
  .din_b     (din_b),
  .dout_b    (dout_b),
  .cfg_we    (cfg_we),
  .cfg_addr  (cfg_addr),
  .cfg_wdata (cfg_wdata),
  .cfg_rdata (cfg_rdata)
);

// ==== tb_clock_gen.sv ====
// Testbench clock with a 4 ns period and a synchronous reset held low for 8 cycles.
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 2;
  localparam int reset_cycles = 8;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
  end

  always #half_period clk = ~clk;

  initial begin
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1; // Released on an edge, like any other stimulus.
  end

endmodule

// ==== shared_ram_top.sv ====
// Top level joining the lock registers, the two write guards and the shared memory.
`timescale 1ns/1ns

module shared_ram_top import dpram_pkg::*; #(
  parameter bit force_x_to_zero = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cs_a,
  input  logic                  we_a,
  input  logic [mask_w-1:0]     wem_a,
  input  logic [addr_w-1:0]     addr_a,
  input  logic [data_w-1:0]     din_a,
  output logic [data_w-1:0]     dout_a,
  input  logic                  cs_b,
  input  logic                  we_b,
  input  logic [mask_w-1:0]     wem_b,
  input  logic [addr_w-1:0]     addr_b,
  input  logic [data_w-1:0]     din_b,
  output logic [data_w-1:0]     dout_b,
  input  logic                  cfg_we,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata
);

  logic              lock_en;
  logic [addr_w-1:0] lock_base;
  logic [addr_w-1:0] lock_limit;
  logic [mask_w-1:0] wen_a;
  logic [mask_w-1:0] wen_b;
  logic              blocked_a;
  logic              blocked_b;

  guard_regs u_guard_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .blocked_a  (blocked_a),
    .blocked_b  (blocked_b),
    .cfg_rdata  (cfg_rdata),
    .lock_en    (lock_en),
    .lock_base  (lock_base),
    .lock_limit (lock_limit)
  );

  // One guard per port, sharing the same window.
  write_guard u_guard_a (
    .cs         (cs_a),
    .we         (we_a),
    .wem        (wem_a),
    .addr       (addr_a),
    .lock_en    (lock_en),
    .lock_base  (lock_base),
    .lock_limit (lock_limit),
    .wen        (wen_a),
    .blocked    (blocked_a)
  );

  write_guard u_guard_b (
    .cs         (cs_b),
    .we         (we_b),
    .wem        (wem_b),
    .addr       (addr_b),
    .lock_en    (lock_en),
    .lock_base  (lock_base),
    .lock_limit (lock_limit),
    .wen        (wen_b),
    .blocked    (blocked_b)
  );

  shared_ram_core #(
    .force_x_to_zero (force_x_to_zero)
  ) u_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .cs_a   (cs_a),
    .cs_b   (cs_b),
    .addr_a (addr_a),
    .addr_b (addr_b),
    .din_a  (din_a),
    .din_b  (din_b),
    .wen_a  (wen_a),
    .wen_b  (wen_b),
    .dout_a (dout_a),
    .dout_b (dout_b)
  );

endmodule

// ==== guard_regs.sv ====
// Lock window configuration registers and the saturating blocked-write counter.
`timescale 1ns/1ns

module guard_regs import dpram_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_we,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  input  logic                  blocked_a,
  input  logic                  blocked_b,
  output logic [cfg_data_w-1:0] cfg_rdata,
  output logic                  lock_en,
  output logic [addr_w-1:0]     lock_base,
  output logic [addr_w-1:0]     lock_limit
);

  logic [cfg_data_w-1:0] blocked_cnt;
  logic [1:0]            blocked_inc;
  logic [cfg_data_w-1:0] cnt_headroom;
  logic                  cnt_clear;

  // Base, limit and control keep only the bits they use.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock_base  <= '0;
      lock_limit <= '0;
      lock_en    <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_addr)
        reg_lock_base:  lock_base  <= cfg_wdata[addr_w-1:0];
        reg_lock_limit: lock_limit <= cfg_wdata[addr_w-1:0];
        reg_lock_ctrl:  lock_en    <= cfg_wdata[0];
        default: ;
      endcase
    end
  end

  // Both ports can be blocked in the same cycle.
  assign blocked_inc  = {1'b0, blocked_a} + {1'b0, blocked_b};
  assign cnt_headroom = cnt_max - blocked_cnt;
  assign cnt_clear    = cfg_we && (cfg_addr == reg_blocked_cnt);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blocked_cnt <= '0;
    end else if (cnt_clear) begin
      blocked_cnt <= '0; // Clearing wins over a count in the same cycle.
    end else if (cfg_data_w'(blocked_inc) > cnt_headroom) begin
      blocked_cnt <= cnt_max;
    end else begin
      blocked_cnt <= blocked_cnt + cfg_data_w'(blocked_inc);
    end
  end

  // Reads are combinational and zero-extended.
  always_comb begin
    case (cfg_addr)
      reg_lock_base:  cfg_rdata = cfg_data_w'(lock_base);
      reg_lock_limit: cfg_rdata = cfg_data_w'(lock_limit);
      reg_lock_ctrl:  cfg_rdata = {{(cfg_data_w-1){1'b0}}, lock_en};
      default:        cfg_rdata = blocked_cnt;
    endcase
  end

endmodule

// ==== write_guard.sv ====
// Per-port write check against the locked window, giving byte enables and a blocked pulse.
`timescale 1ns/1ns

module write_guard import dpram_pkg::*; (
  input  logic              cs,
  input  logic              we,
  input  logic [mask_w-1:0] wem,
  input  logic [addr_w-1:0] addr,
  input  logic              lock_en,
  input  logic [addr_w-1:0] lock_base,
  input  logic [addr_w-1:0] lock_limit,
  output logic [mask_w-1:0] wen,
  output logic              blocked
);

  logic              wr_req;
  logic              in_window;
  logic [mask_w-1:0] wem_qual;

  // A write is requested on cs and we, even with an empty byte mask.
  assign wr_req   = cs & we;
  assign wem_qual = wem & {mask_w{wr_req}};

  // Both bounds belong to the window.
  assign in_window = lock_en && (addr >= lock_base) && (addr <= lock_limit);

  // A hit drops the whole write and is reported for counting.
  assign blocked = wr_req & in_window;
  assign wen     = blocked ? '0 : wem_qual;

endmodule

// ==== shared_ram_core.sv ====
// Dual-port byte-masked scratchpad memory with registered read addresses and port A priority.
`timescale 1ns/1ns

module shared_ram_core import dpram_pkg::*; #(
  parameter bit force_x_to_zero = 1'b0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cs_a,
  input  logic              cs_b,
  input  logic [addr_w-1:0] addr_a,
  input  logic [addr_w-1:0] addr_b,
  input  logic [data_w-1:0] din_a,
  input  logic [data_w-1:0] din_b,
  input  logic [mask_w-1:0] wen_a,
  input  logic [mask_w-1:0] wen_b,
  output logic [data_w-1:0] dout_a,
  output logic [data_w-1:0] dout_b
);

  logic [data_w-1:0] mem [mem_depth];
  logic [addr_w-1:0] addr_a_q;
  logic [addr_w-1:0] addr_b_q;
  logic              same_addr;
  logic [mask_w-1:0] wen_b_eff;
  logic [data_w-1:0] dout_pre_a;
  logic [data_w-1:0] dout_pre_b;

  // Contents start at zero in simulation and are not touched by reset.
  initial begin
    for (int j = 0; j < mem_depth; j++) begin
      mem[j] = '0;
    end
  end

  // Port B loses only the bytes that port A writes to the same word.
  assign same_addr = (addr_a == addr_b);
  assign wen_b_eff = wen_b & ~(wen_a & {mask_w{same_addr}});

  // Once port B is masked, the two ports never write the same byte of the same word.
  always_ff @(posedge clk) begin
    for (int i = 0; i < mask_w; i++) begin
      if (wen_a[i]) begin
        mem[addr_a][8*i +: 8] <= din_a[8*i +: 8];
      end
      if (wen_b_eff[i]) begin
        mem[addr_b][8*i +: 8] <= din_b[8*i +: 8];
      end
    end
  end

  // Each chip select captures its read address, which is held while cs is low.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_a_q <= '0;
    end else if (cs_a) begin
      addr_a_q <= addr_a;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_b_q <= '0;
    end else if (cs_b) begin
      addr_b_q <= addr_b;
    end
  end

  // The outputs follow the live contents of the registered word.
  assign dout_pre_a = mem[addr_a_q];
  assign dout_pre_b = mem[addr_b_q];

  generate
    if (force_x_to_zero) begin : gen_x_to_zero
      // An unknown bit is shown as zero, which only matters in simulation.
      for (genvar b = 0; b < data_w; b++) begin : gen_bit
        assign dout_a[b] = (dout_pre_a[b] === 1'bx) ? 1'b0 : dout_pre_a[b];
        assign dout_b[b] = (dout_pre_b[b] === 1'bx) ? 1'b0 : dout_pre_b[b];
      end
    end else begin : gen_plain_out
      assign dout_a = dout_pre_a;
      assign dout_b = dout_pre_b;
    end
  endgenerate

endmodule

// ==== dpram_pkg.sv ====
// Memory geometry, configuration register map and blocked counter limits for the scratchpad.
package dpram_pkg;

  // The scratchpad holds 1024 words of 32 bits.
  localparam int mem_depth = 1024;
  localparam int addr_w    = $clog2(mem_depth); // 10 bits of word address.
  localparam int data_w    = 32;
  localparam int mask_w    = data_w / 8;        // One enable per byte lane.

  // Configuration port geometry.
  localparam int cfg_addr_w = 2;
  localparam int cfg_data_w = 16;

  // Register map.
  // Base and limit hold word addresses, and both ends of the window are locked.
  localparam logic [cfg_addr_w-1:0] reg_lock_base   = 2'd0; // First locked word.
  localparam logic [cfg_addr_w-1:0] reg_lock_limit  = 2'd1; // Last locked word.
  localparam logic [cfg_addr_w-1:0] reg_lock_ctrl   = 2'd2; // Bit 0 enables the lock.
  localparam logic [cfg_addr_w-1:0] reg_blocked_cnt = 2'd3; // Read only, a write clears it.

  // The blocked-write counter is as wide as a register and sticks at all ones.
  localparam logic [cfg_data_w-1:0] cnt_max = '1;

endpackage
